// ==== src/ttc_reg_pkg.sv ====
/* Timer register map and write word types */

`default_nettype none

package ttc_reg_pkg;

  // --------------------------------------------------------------------------
  // Register addresses
  // --------------------------------------------------------------------------
  typedef enum logic [3:0] {
    TTC_ADDR_CTRL     = 4'h0,  // Counter control
    TTC_ADDR_INTERVAL = 4'h1,  // Interval value
    TTC_ADDR_MATCH_1  = 4'h2,
    TTC_ADDR_MATCH_2  = 4'h3,
    TTC_ADDR_MATCH_3  = 4'h4,
    TTC_ADDR_COUNT    = 4'h5,  // Read only
    TTC_ADDR_PRESC    = 4'h6,  // Prescale divider
    TTC_ADDR_STATUS   = 4'h7,  // W1C
    TTC_ADDR_IRQ_EN   = 4'h8   // Interrupt enable mask
  } ttc_addr_e;

  // Control bits, MSB first so bit 0 lands on cnt_disable
  typedef struct packed {
    logic wave_polarity;  // Bit 6, stored only
    logic wave_disable;   // Bit 5, stored only
    logic restart;        // Bit 4, self clearing
    logic match_mode;     // Bit 3
    logic decrement;      // Bit 2
    logic interval_mode;  // Bit 1
    logic cnt_disable;    // Bit 0, high stops count
  } ttc_ctrl_t;

  // One write word, two views
  typedef union packed {
    logic [15:0] raw;
    struct packed {
      logic [8:0] pad;
      ttc_ctrl_t  ctrl;
    } fld;
  } ttc_wdata_u;

  // Counter block write selects
  typedef struct packed {
    logic ctrl;
    logic interval;
    logic match_1;
    logic match_2;
    logic match_3;
  } ttc_sel_t;

endpackage

`default_nettype wire

// ==== src/ttc_irq_pkg.sv ====
/* Timer interrupt types */

`default_nettype none

package ttc_irq_pkg;

  // --------------------------------------------------------------------------
  // Interrupt vector
  // --------------------------------------------------------------------------

  // Number of interrupt sources
  parameter int TTC_IRQ_N = 5;

  // Layout matches the status and enable registers
  //   bit 0    interval
  //   bit 3:1  match 3 to 1
  //   bit 4    overflow
  typedef struct packed {
    logic       overflow;  // Count wrapped to zero
    logic [3:1] match;     // Count equals match register
    logic       interval;  // Interval reached
  } ttc_irq_t;

endpackage

`default_nettype wire

// ==== src/ttc_reg_port.sv ====
/* Timer register port */

`timescale 1ns/1ps
`default_nettype none

module ttc_reg_port
  import ttc_reg_pkg::*;
  import ttc_irq_pkg::*;
#(
  parameter int unsigned PRESC_W = 8
) (
  input  wire                pclk29,
  input  wire                n_p_reset29,
  input  wire                wr,          // Single-cycle write strobe
  input  wire  [3:0]         addr,
  input  ttc_wdata_u         wdata,
  input  ttc_ctrl_t          ctrl,        // Readback from counter block
  input  wire  [15:0]        interval,
  input  wire  [15:0]        match_1,
  input  wire  [15:0]        match_2,
  input  wire  [15:0]        match_3,
  input  wire  [15:0]        count_val,
  input  ttc_irq_t           status,      // Readback from status block
  input  ttc_irq_t           irq_en,
  output ttc_sel_t           sel,
  output logic [PRESC_W-1:0] prescale,
  output logic               presc_wr,
  output logic               status_clr,
  output logic               irq_en_wr,
  output logic [15:0]        rdata        // Combinational on addr
);

  // --------------------------------------------------------------------------
  // Write decode
  // --------------------------------------------------------------------------
  always_comb
  begin
    sel        = '0;
    presc_wr   = 1'b0;
    status_clr = 1'b0;
    irq_en_wr  = 1'b0;
    if (wr)
    begin
      case (ttc_addr_e'(addr))
        TTC_ADDR_CTRL:     sel.ctrl     = 1'b1;
        TTC_ADDR_INTERVAL: sel.interval = 1'b1;
        TTC_ADDR_MATCH_1:  sel.match_1  = 1'b1;
        TTC_ADDR_MATCH_2:  sel.match_2  = 1'b1;
        TTC_ADDR_MATCH_3:  sel.match_3  = 1'b1;
        TTC_ADDR_PRESC:    presc_wr     = 1'b1;
        TTC_ADDR_STATUS:   status_clr   = 1'b1;
        TTC_ADDR_IRQ_EN:   irq_en_wr    = 1'b1;
        default: ;                              // Count and holes ignore writes
      endcase
    end
  end

  // Prescale register, 0 after reset gives a count every cycle
  always_ff @(posedge pclk29 or negedge n_p_reset29)
  begin
    if (!n_p_reset29)
      prescale <= '0;
    else if (presc_wr)
      prescale <= wdata.raw[PRESC_W-1:0];
  end

  // --------------------------------------------------------------------------
  // Read mux, narrow fields zero extended
  // --------------------------------------------------------------------------
  always_comb
  begin
    case (ttc_addr_e'(addr))
      TTC_ADDR_CTRL:     rdata = 16'(ctrl);
      TTC_ADDR_INTERVAL: rdata = interval;
      TTC_ADDR_MATCH_1:  rdata = match_1;
      TTC_ADDR_MATCH_2:  rdata = match_2;
      TTC_ADDR_MATCH_3:  rdata = match_3;
      TTC_ADDR_COUNT:    rdata = count_val;
      TTC_ADDR_PRESC:    rdata = 16'(prescale);
      TTC_ADDR_STATUS:   rdata = 16'(status);
      TTC_ADDR_IRQ_EN:   rdata = 16'(irq_en);
      default:           rdata = 16'h0000;      // Unmapped
    endcase
  end

endmodule

`default_nettype wire

// ==== src/ttc_prescaler.sv ====
/* Timer prescaler */

`timescale 1ns/1ps
`default_nettype none

module ttc_prescaler #(
  parameter int unsigned PRESC_W = 8
) (
  input  wire               pclk29,
  input  wire               n_p_reset29,
  input  wire [PRESC_W-1:0] prescale,   // Divide by prescale+1
  input  wire               presc_wr,   // Restart divider
  output logic              count_en    // One cycle per period
);

  logic [PRESC_W-1:0] div_cnt;          // 0 up to prescale
  logic               term_cnt;

  // --------------------------------------------------------------------------
  // Divider
  // --------------------------------------------------------------------------
  assign term_cnt = (div_cnt == prescale);

  always_ff @(posedge pclk29 or negedge n_p_reset29)
  begin
    if (!n_p_reset29)
      div_cnt <= '0;
    else if (presc_wr)
      div_cnt <= '0;                    // New period starts from zero
    else if (term_cnt)
      div_cnt <= '0;                    // Wrap
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // Pulse at terminal count
  // prescale 0 keeps it high every cycle
  assign count_en = term_cnt;

endmodule

`default_nettype wire

// ==== src/ttc_counter_lite.sv ====
/* Timer counter with match and interval */

`timescale 1ns/1ps
`default_nettype none

module ttc_counter_lite
  import ttc_reg_pkg::*;
  import ttc_irq_pkg::*;
(
  input  wire         pclk29,
  input  wire         n_p_reset29,
  input  ttc_wdata_u  wdata,
  input  ttc_sel_t    sel,          // Register write selects
  input  wire         count_en,     // From prescaler
  output ttc_ctrl_t   ctrl,
  output logic [15:0] interval,
  output logic [15:0] match_1,
  output logic [15:0] match_2,
  output logic [15:0] match_3,
  output logic [15:0] count_val,
  output ttc_irq_t    irq_lvl       // Level conditions, not sticky
);

  logic        counting;            // Set once counting has begun
  logic        restart_done;        // Restart load seen, clear the bit
  logic [15:0] next_val;            // Value for next count_en edge
  logic [15:0] start_val;           // Restart load value
  logic        irq_live;            // Interrupt qualifier

  // --------------------------------------------------------------------------
  // Register file
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk29 or negedge n_p_reset29)
  begin
    if (!n_p_reset29)
    begin
      ctrl     <= ttc_ctrl_t'(7'b000_0001);  // Counter disabled
      interval <= 16'h0000;
      match_1  <= 16'h0000;
      match_2  <= 16'h0000;
      match_3  <= 16'h0000;
    end
    else
    begin
      // A software write beats the restart self clear
      if (sel.ctrl)
        ctrl <= wdata.fld.ctrl;
      else if (restart_done)
        ctrl.restart <= 1'b0;

      if (sel.interval)
        interval <= wdata.raw;
      if (sel.match_1)
        match_1 <= wdata.raw;
      if (sel.match_2)
        match_2 <= wdata.raw;
      if (sel.match_3)
        match_3 <= wdata.raw;
    end
  end

  // --------------------------------------------------------------------------
  // Next count
  // --------------------------------------------------------------------------

  // Up starts at 0, down starts at interval or top
  assign start_val = !ctrl.decrement   ? 16'h0000 :
                     ctrl.interval_mode ? interval  : 16'hFFFF;

  always_comb
  begin
    next_val = count_val;
    if (ctrl.interval_mode)
    begin
      if (ctrl.decrement)
      begin
        if (count_val == 16'h0000)
          next_val = interval;                // Reload
        else
          next_val = count_val - 16'h0001;
      end
      else
      begin
        if (count_val == interval)
          next_val = 16'h0000;                // Wrap at interval
        else
          next_val = count_val + 16'h0001;
      end
    end
    else if (ctrl.decrement)
      next_val = count_val - 16'h0001;        // 0 wraps to FFFF
    else
      next_val = count_val + 16'h0001;        // FFFF wraps to 0
  end

  // --------------------------------------------------------------------------
  // Counter
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk29 or negedge n_p_reset29)
  begin
    if (!n_p_reset29)
    begin
      count_val    <= 16'h0000;
      counting     <= 1'b0;
      restart_done <= 1'b0;
    end
    else if (count_en)
    begin
      if (ctrl.restart)
      begin
        count_val    <= start_val;
        counting     <= 1'b0;                 // Hold off interrupts
        restart_done <= 1'b1;
      end
      else
      begin
        if (!ctrl.cnt_disable)
        begin
          count_val <= next_val;
          counting  <= 1'b1;
        end
        restart_done <= 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Interrupt conditions
  // --------------------------------------------------------------------------
  assign irq_live = counting & ~ctrl.restart & ~ctrl.cnt_disable;

  always_comb
  begin
    irq_lvl          = '0;
    irq_lvl.interval = irq_live &  ctrl.interval_mode & (count_val == 16'h0000);
    irq_lvl.overflow = irq_live & ~ctrl.interval_mode & (count_val == 16'h0000);
    irq_lvl.match[1] = irq_live & ctrl.match_mode & (count_val == match_1);
    irq_lvl.match[2] = irq_live & ctrl.match_mode & (count_val == match_2);
    irq_lvl.match[3] = irq_live & ctrl.match_mode & (count_val == match_3);
  end

endmodule

`default_nettype wire

// ==== src/ttc_intr_status.sv ====
/* Timer interrupt status */

`timescale 1ns/1ps
`default_nettype none

module ttc_intr_status
  import ttc_reg_pkg::*;
  import ttc_irq_pkg::*;
(
  input  wire        pclk29,
  input  wire        n_p_reset29,
  input  ttc_irq_t   irq_lvl,      // Levels from counter
  input  wire        status_clr,   // W1C strobe
  input  wire        irq_en_wr,    // Enable mask write
  input  ttc_wdata_u wdata,
  output ttc_irq_t   status,       // Sticky events
  output ttc_irq_t   irq_en,
  output logic       irq
);

  logic [TTC_IRQ_N-1:0] clr_mask;  // Bits written with one

  // --------------------------------------------------------------------------
  // Status and enable registers
  // --------------------------------------------------------------------------
  assign clr_mask = status_clr ? wdata.raw[TTC_IRQ_N-1:0] : '0;

  always_ff @(posedge pclk29 or negedge n_p_reset29)
  begin
    if (!n_p_reset29)
    begin
      status <= '0;
      irq_en <= '0;
    end
    else
    begin
      // New level wins over a same cycle clear
      status <= ttc_irq_t'((status & ~clr_mask) | irq_lvl);
      if (irq_en_wr)
        irq_en <= ttc_irq_t'(wdata.raw[TTC_IRQ_N-1:0]);
    end
  end

  // Combined request
  assign irq = |(status & irq_en);

endmodule

`default_nettype wire

// ==== src/ttc_timer_top.sv ====
/* Timer top level */

`timescale 1ns/1ps
`default_nettype none

module ttc_timer_top
  import ttc_reg_pkg::*;
  import ttc_irq_pkg::*;
#(
  parameter int unsigned PRESC_W = 8   // Prescaler width, 1 to 16
) (
  input  wire         pclk29,
  input  wire         n_p_reset29,
  input  wire         wr,
  input  wire  [3:0]  addr,
  input  ttc_wdata_u  wdata,
  output logic [15:0] rdata,
  output logic [15:0] count_val,
  output logic        irq
);

  // --------------------------------------------------------------------------
  // Interconnect
  // --------------------------------------------------------------------------
  ttc_sel_t           sel;
  logic [PRESC_W-1:0] prescale;
  logic               presc_wr;
  logic               status_clr;
  logic               irq_en_wr;
  logic               count_en;
  ttc_ctrl_t          ctrl;
  logic [15:0]        interval;
  logic [15:0]        match_1;
  logic [15:0]        match_2;
  logic [15:0]        match_3;
  ttc_irq_t           irq_lvl;
  ttc_irq_t           status;
  ttc_irq_t           irq_en;

  // Register decode and readback
  ttc_reg_port #(.PRESC_W(PRESC_W)) u_reg_port (
    .pclk29, .n_p_reset29, .wr, .addr, .wdata,
    .ctrl, .interval, .match_1, .match_2, .match_3, .count_val,
    .status, .irq_en,
    .sel, .prescale, .presc_wr, .status_clr, .irq_en_wr, .rdata
  );

  ttc_prescaler #(.PRESC_W(PRESC_W)) u_prescaler (
    .pclk29, .n_p_reset29, .prescale, .presc_wr, .count_en
  );

  ttc_counter_lite u_counter (
    .pclk29, .n_p_reset29, .wdata, .sel, .count_en,
    .ctrl, .interval, .match_1, .match_2, .match_3, .count_val, .irq_lvl
  );

  // Sticky events and irq
  ttc_intr_status u_status (
    .pclk29, .n_p_reset29, .irq_lvl, .status_clr, .irq_en_wr, .wdata,
    .status, .irq_en, .irq
  );

endmodule

`default_nettype wire

// ==== tb/ttc_checker.sv ====
/* Timer reference model and checker */

`timescale 1ns/1ps
`default_nettype none

module ttc_checker
  import ttc_reg_pkg::*;
#(
  parameter int unsigned PRESC_W = 8
) (
  input wire         pclk29,
  input wire         n_p_reset29,
  input wire         wr,
  input wire  [3:0]  addr,
  input ttc_wdata_u  wdata,
  input wire  [15:0] rdata,
  input wire  [15:0] count_val,
  input wire         irq
);

  integer             checks = 0;
  integer             errors = 0;
  logic [6:0]         m_ctrl;           // Bit 0 disable, bit 4 restart
  logic [15:0]        m_intv;
  logic [15:0]        m_match [0:2];    // Match 1 to 3
  logic [15:0]        m_cnt;
  logic               m_counting;       // Cleared by restart load
  logic               m_rdone;          // Restart load taken
  logic [PRESC_W-1:0] m_presc;
  logic [PRESC_W-1:0] m_div;
  logic [4:0]         m_stat;           // Interval, match 1 to 3, overflow
  logic [4:0]         m_en;

  // Expected read data per address
  function automatic logic [15:0] model_read(input logic [3:0] a);
    case (a)
      4'h0:             model_read = {9'h000, m_ctrl};
      4'h1:             model_read = m_intv;
      4'h2, 4'h3, 4'h4: model_read = m_match[a - 4'h2];
      4'h5:             model_read = m_cnt;
      4'h6:             model_read = 16'(m_presc);   // Zero extended
      4'h7:             model_read = {11'h000, m_stat};
      4'h8:             model_read = {11'h000, m_en};
      default:          model_read = 16'h0000;       // Holes
    endcase
  endfunction

  task automatic compare(input string name, input logic [15:0] exp_val,
                         input logic [15:0] dut_val);
    checks = checks + 1;
    if (dut_val !== exp_val)
    begin
      errors = errors + 1;
      $display("Mismatch at %0t ns: %s expected %h, DUT %h",
               $time, name, exp_val, dut_val);
    end
  endtask

  // --------------------------------------------------------------------------
  // Cycle model, outputs compared against pre-edge state
  // --------------------------------------------------------------------------
  always @(posedge pclk29)
  begin : step
    logic        en;
    logic        live;
    logic [4:0]  lvl;
    logic [15:0] nxt;
    logic [6:0]  nctrl;
    int          k;
    if (!n_p_reset29)
    begin
      m_ctrl     = 7'h01;                // Disabled out of reset
      m_intv     = 16'h0000;
      m_match[0] = 16'h0000;
      m_match[1] = 16'h0000;
      m_match[2] = 16'h0000;
      m_cnt      = 16'h0000;
      m_counting = 1'b0;
      m_rdone    = 1'b0;
      m_presc    = '0;
      m_div      = '0;
      m_stat     = 5'h00;
      m_en       = 5'h00;
    end
    else
    begin
      compare("rdata", model_read(addr), rdata);
      compare("count_val", m_cnt, count_val);
      compare("irq", {15'h0000, |(m_stat & m_en)}, {15'h0000, irq});

      // Levels from current state
      en     = (m_div == m_presc);
      live   = m_counting & ~m_ctrl[4] & ~m_ctrl[0];
      lvl[0] = live & m_ctrl[1] & (m_cnt == 16'h0000);
      lvl[4] = live & ~m_ctrl[1] & (m_cnt == 16'h0000);
      for (k = 1; k <= 3; k++)
        lvl[k] = live & m_ctrl[3] & (m_cnt == m_match[k - 1]);

      if (m_ctrl[1] && m_ctrl[2])        // Interval down, reload at 0
        nxt = (m_cnt == 16'h0000) ? m_intv : m_cnt - 16'h0001;
      else if (m_ctrl[1])                // Interval up, wrap at interval
        nxt = (m_cnt == m_intv) ? 16'h0000 : m_cnt + 16'h0001;
      else
        nxt = m_ctrl[2] ? m_cnt - 16'h0001 : m_cnt + 16'h0001;

      nctrl = m_ctrl;
      if (wr && addr == 4'h0)
        nctrl = wdata.raw[6:0];
      else if (m_rdone)
        nctrl[4] = 1'b0;                 // Restart self clear

      if (en)
      begin
        if (m_ctrl[4])
        begin
          m_cnt      = !m_ctrl[2] ? 16'h0000 : (m_ctrl[1] ? m_intv : 16'hFFFF);
          m_counting = 1'b0;
          m_rdone    = 1'b1;
        end
        else
        begin
          if (!m_ctrl[0])
          begin
            m_cnt      = nxt;
            m_counting = 1'b1;
          end
          m_rdone = 1'b0;
        end
      end
      m_ctrl = nctrl;

      m_div  = ((wr && addr == 4'h6) || en) ? '0 : m_div + 1'b1;
      m_stat = (m_stat & ~((wr && addr == 4'h7) ? wdata.raw[4:0] : 5'h00)) | lvl;
      if (wr)
        case (addr)
          4'h1:             m_intv = wdata.raw;
          4'h2, 4'h3, 4'h4: m_match[addr - 4'h2] = wdata.raw;
          4'h6:             m_presc = wdata.raw[PRESC_W-1:0];
          4'h8:             m_en = wdata.raw[4:0];
          default: ;                     // Count and holes ignore writes
        endcase
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_ttc_top.sv ====
/* Timer testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_ttc_top
  import ttc_reg_pkg::*;
();

  localparam int unsigned PRESC_W = 8;
  localparam int          N_OPS   = 400;
  localparam int          LIMIT   = 20 + N_OPS * 40;  // Cycle budget

  logic        pclk29;
  logic        n_p_reset29;
  logic        wr;
  logic [3:0]  addr;
  ttc_wdata_u  wdata;
  logic [15:0] rdata;
  logic [15:0] count_val;
  logic        irq;
  integer      seed = 32'h5d3a;
  logic [3:0]  rd_ptr;                 // Read address walk while idle
  int          cycles = 0;

  ttc_timer_top #(.PRESC_W(PRESC_W)) u_dut (
    .pclk29, .n_p_reset29, .wr, .addr, .wdata, .rdata, .count_val, .irq
  );

  ttc_checker #(.PRESC_W(PRESC_W)) u_chk (
    .pclk29, .n_p_reset29, .wr, .addr, .wdata, .rdata, .count_val, .irq
  );

  initial
  begin
    pclk29 = 1'b0;
    forever #5 pclk29 = ~pclk29;      // 10 ns period
  end

  // Run length guard
  always @(posedge pclk29)
  begin
    cycles = cycles + 1;
    if (cycles > LIMIT)
    begin
      $display("Timeout after %0d cycles, register traffic did not finish", LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // One random write, then idle cycles reading each address in turn
  // --------------------------------------------------------------------------
  task automatic run_op;
    logic [31:0] r;
    logic [3:0]  a;
    logic [15:0] d;
    logic [4:0]  idle;
    r = $random(seed);
    case (r[3:0])
      4'h0, 4'h1, 4'h2, 4'h3, 4'h4: a = 4'h0;   // Control
      4'h5, 4'h6:                   a = 4'h6;   // Prescale
      default:                      a = r[11:8];
    endcase
    idle = r[20:16] % 5'd31;                   // 0 to 30
    r = $random(seed);
    d = r[15:0];
    if (a == 4'h0)
      d = {9'h000, d[6:5], d[4] & d[11], d[3:1], d[0] & d[10]};  // Restart, disable rarer
    else if (a == 4'h6)
      d = d[15] ? {14'h0000, d[1:0]} : {12'h000, d[3:0]};
    else if (a >= 4'h1 && a <= 4'h4 && d[15])
      d = {10'h000, d[5:0]};                   // Small values, hit often
    wr        = 1'b1;
    addr      = a;
    wdata.raw = d;
    @(negedge pclk29);
    wr = 1'b0;
    repeat (idle)
    begin
      addr   = rd_ptr;
      rd_ptr = rd_ptr + 4'h1;
      @(negedge pclk29);
    end
  endtask

  initial
  begin
    n_p_reset29 = 1'b0;
    wr          = 1'b0;
    addr        = 4'h0;
    wdata       = '0;
    rd_ptr      = 4'h0;
    repeat (10) @(posedge pclk29);     // Reset for 10 cycles
    @(negedge pclk29);
    n_p_reset29 = 1'b1;
    for (int i = 0; i < N_OPS; i++)
      run_op();
    @(negedge pclk29);
    $display("Ops %0d, checks %0d, errors %0d", N_OPS, u_chk.checks, u_chk.errors);
    if (u_chk.errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
src/ttc_reg_pkg.sv
src/ttc_irq_pkg.sv
src/ttc_reg_port.sv
src/ttc_prescaler.sv
src/ttc_counter_lite.sv
src/ttc_intr_status.sv
src/ttc_timer_top.sv
tb/ttc_checker.sv
tb/tb_ttc_top.sv

// ==== Makefile ====
# Verilator build and run of the timer testbench

TOP = tb_ttc_top
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
